//--- bench/cpu_checker.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_checker #(
	parameter int          MEM_WORDS = 256,
	parameter logic [31:0] RESET_PC  = 32'h0000_0000
) (
	input  wire                         clk,
	input  wire                         reset,
	input  wire                         load_en,
	input  wire [$clog2(MEM_WORDS)-1:0] load_addr,
	input  wire [31:0]                  load_data,
	input  wire                         halt,
	input  wire cpu_pkg::retire_t       retire,
	input  wire                         retire_valid,
	output int                          error_count
);

	localparam int AW = $clog2(MEM_WORDS);

	// Reference machine state
	logic [31:0] mem [MEM_WORDS];
	logic [31:0] regs [32];
	logic [31:0] model_pc;

	initial error_count = 0;

	task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			error_count++;
			$display("[FAIL] %0t: %s wrong at pc %h, got %h, expected %h",
				$time, what, model_pc, got, exp);
		end
	endtask

	// Executes one instruction on the model and checks the retire record against it
	task automatic step_model();
		logic [31:0] w, a, b, sext, zext, res, nxt, addr, br_tgt, jmp_tgt;
		logic [4:0]  dst;
		logic        we;
		logic        mwe;
		w = mem[model_pc[2 +: AW]];
		a = regs[w[25:21]];
		b = regs[w[20:16]];
		sext = {{16{w[15]}}, w[15:0]};
		zext = {16'd0, w[15:0]};
		nxt = model_pc + 32'd4;
		br_tgt = model_pc + (sext << 2);
		jmp_tgt = {nxt[31:28], w[25:0], 2'b00};
		res = 32'd0;
		addr = 32'd0;
		dst = w[20:16];
		we = 1'b0;
		mwe = 1'b0;
		compare("pc", retire.pc, model_pc);
		compare("instr", retire.instr, w);
		if (w == 32'd0) begin
			// Halt word, the PC stays put and nothing is written
			compare("halt", 32'(halt), 32'd1);
			compare("retire_valid", 32'(retire_valid), 32'd0);
			compare("reg_we", 32'(retire.reg_we), 32'd0);
			compare("mem_we", 32'(retire.mem_we), 32'd0);
		end else begin
			case (w[31:26])
				6'h00: begin
					dst = w[15:11];
					we = 1'b1;
					case (w[5:0])
						6'h21: res = a + b;
						6'h23: res = a - b;
						6'h24: res = a & b;
						6'h25: res = a | b;
						6'h26: res = a ^ b;
						6'h27: res = ~(a | b);
						6'h2a: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						6'h2b: res = (a < b) ? 32'd1 : 32'd0;
						6'h00: res = b << w[10:6];
						6'h02: res = b >> w[10:6];
						6'h03: res = $signed(b) >>> w[10:6];
						6'h04: res = b << a[4:0];
						6'h06: res = b >> a[4:0];
						6'h07: res = $signed(b) >>> a[4:0];
						6'h08: begin
							we = 1'b0;
							nxt = a;
						end
						6'h09: begin
							res = nxt;
							nxt = a;
						end
						default: we = 1'b0;
					endcase
				end
				6'h02: nxt = jmp_tgt;
				6'h03: begin
					res = nxt;
					nxt = jmp_tgt;
					we = 1'b1;
					dst = 5'd31;
				end
				6'h04: nxt = (a == b) ? br_tgt : nxt;
				6'h05: nxt = (a != b) ? br_tgt : nxt;
				6'h06: nxt = ($signed(a) <= 0) ? br_tgt : nxt;
				6'h07: nxt = ($signed(a) > 0) ? br_tgt : nxt;
				6'h2b: begin
					addr = a + sext;
					mwe = 1'b1;
				end
				default: begin
					// Immediate forms and lw write rt
					we = 1'b1;
					case (w[31:26])
						6'h09: res = a + sext;
						6'h0a: res = ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
						6'h0b: res = (a < sext) ? 32'd1 : 32'd0;
						6'h0c: res = a & zext;
						6'h0d: res = a | zext;
						6'h0e: res = a ^ zext;
						6'h0f: res = {w[15:0], 16'd0};
						6'h23: begin
							addr = a + sext;
							res = mem[addr[2 +: AW]];
						end
						default: we = 1'b0;
					endcase
				end
			endcase
			compare("halt", 32'(halt), 32'd0);
			compare("retire_valid", 32'(retire_valid), 32'd1);
			compare("reg_we", 32'(retire.reg_we), 32'(we));
			compare("mem_we", 32'(retire.mem_we), 32'(mwe));
			if (we) begin
				compare("wb_addr", 32'(retire.wb_addr), 32'(dst));
				compare("wb_data", retire.wb_data, res);
			end
			if (mwe) begin
				compare("mem_addr", retire.mem_addr, addr);
			end
			// r0 never changes
			if (we && dst != 5'd0) begin
				regs[dst] = res;
			end
			if (mwe) begin
				mem[addr[2 +: AW]] = b;
			end
			model_pc = nxt;
		end
	endtask

	always @(posedge clk) begin
		if (reset) begin
			compare("retire_valid", 32'(retire_valid), 32'd0);
			if (load_en) begin
				mem[load_addr] = load_data;
			end
			for (int i = 0; i < 32; i++) begin
				regs[i] = 32'd0;
			end
			model_pc = RESET_PC;
		end else begin
			step_model();
		end
	end

endmodule

`default_nettype wire

//--- bench/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;

	localparam int MEM_WORDS = 256;
	localparam int AW = $clog2(MEM_WORDS);
	localparam int PROGRAMS = 8;
	localparam int PROG_WORDS = 48;
	localparam int TIMEOUT_CYCLES = PROGRAMS * (PROG_WORDS + 1 + MEM_WORDS + 4) * 2;

	// addu subu and or xor nor slt sltu sll srl sra sllv srlv srav
	localparam logic [5:0] R_FUNCTS [14] = '{6'h21, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27,
		6'h2a, 6'h2b, 6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07};
	// addiu slti sltiu andi ori xori lui
	localparam logic [5:0] I_OPCS [7] = '{6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f};
	localparam logic [5:0] BR_OPCS [4] = '{6'h04, 6'h05, 6'h06, 6'h07};

	logic              clk;
	logic              reset;
	logic              load_en;
	logic [AW-1:0]     load_addr;
	logic [31:0]       load_data;
	logic              halt;
	logic              retire_valid;
	cpu_pkg::retire_t  retire;
	int                mismatches;
	int                timeouts = 0;
	int                cycles = 0;
	logic [31:0]       rand_state = 32'd13600;
	logic [31:0]       image [MEM_WORDS];

	cpu_top #(.MEM_WORDS(MEM_WORDS), .RESET_PC(32'h0000_0000)) dut (
		.clk, .reset, .load_en, .load_addr, .load_data,
		.halt, .retire, .retire_valid
	);

	cpu_checker #(.MEM_WORDS(MEM_WORDS), .RESET_PC(32'h0000_0000)) chk (
		.clk, .reset, .load_en, .load_addr, .load_data,
		.halt, .retire, .retire_valid, .error_count(mismatches)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) cycles <= cycles + 1;

	function automatic int rand_below(input int n);
		rand_state = rand_state * 32'd1664525 + 32'd1013904223;
		return int'(rand_state[31:16]) % n;
	endfunction

	function automatic logic [31:0] r_type(input int rs, input int rt, input int rd,
			input int sa, input logic [5:0] fn);
		return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'(sa), fn};
	endfunction

	function automatic logic [31:0] i_type(input logic [5:0] opc, input int rs, input int rt,
			input logic [15:0] imm);
		return {opc, 5'(rs), 5'(rt), imm};
	endfunction

	function automatic logic [31:0] j_type(input logic [5:0] opc, input int target_word);
		return {opc, 26'(target_word)};
	endfunction

	// Control transfers only go forward; targets stop at word 40 ahead of the call segment
	function automatic logic [31:0] gen_instr(input int word);
		int          kind;
		int          max_tgt;
		int          rt;
		logic [5:0]  opc;
		logic [31:0] w;
		kind = rand_below(10);
		max_tgt = (word < 40) ? 40 : PROG_WORDS;
		case (kind)
			0, 1, 2: w = r_type(rand_below(32), rand_below(32), rand_below(32),
				rand_below(32), R_FUNCTS[rand_below(14)]);
			3, 4, 9: w = i_type(I_OPCS[rand_below(7)], rand_below(32), rand_below(32),
				16'(rand_below(65536)));
			5: w = i_type(6'h23, 0, rand_below(32), 16'(4 * (192 + rand_below(64))));
			6: w = i_type(6'h2b, 0, rand_below(32), 16'(4 * (192 + rand_below(64))));
			7: begin
				opc = BR_OPCS[rand_below(4)];
				rt = (opc == 6'h04 || opc == 6'h05) ? rand_below(32) : 0;
				w = i_type(opc, rand_below(32), rt, 16'(1 + rand_below(max_tgt - word)));
			end
			default: begin
				opc = (rand_below(2) == 1) ? 6'h03 : 6'h02;
				w = j_type(opc, word + 1 + rand_below(max_tgt - word));
			end
		endcase
		// sll r0,r0,0 would halt early
		if (w == 32'd0) begin
			w = 32'h0000_0021;
		end
		return w;
	endfunction

	task automatic build_program(input int p);
		int slot;
		for (int w = 0; w < PROG_WORDS; w++) begin
			image[w] = gen_instr(w);
		end
		// jal into a jr r31 return, then jalr through r30 to word 44
		image[40] = i_type(6'h09, 0, 30, 16'd176);
		image[41] = j_type(6'h03, 43);
		image[42] = r_type(30, 0, 29, 0, 6'h09);
		image[43] = r_type(31, 0, 0, 0, 6'h08);
		// Store the jalr link from r29 and read the same word back into r28
		slot = 4 * (192 + rand_below(64));
		image[44] = i_type(6'h2b, 0, 29, 16'(slot));
		image[45] = i_type(6'h23, 0, 28, 16'(slot));
		image[PROG_WORDS] = 32'd0;
		for (int a = PROG_WORDS + 1; a < MEM_WORDS; a++) begin
			image[a] = (a * 32'h9e37_79b1) ^ (p << 24);
		end
	endtask

	task automatic load_image();
		for (int a = 0; a < MEM_WORDS; a++) begin
			load_en = 1'b1;
			load_addr = AW'(a);
			load_data = image[a];
			@(negedge clk);
		end
		load_en = 1'b0;
		reset = 1'b0;
	endtask

	task automatic report_summary();
		$display("Summary: %0d mismatches, %0d timeouts", mismatches, timeouts);
		if (mismatches == 0 && timeouts == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
	endtask

	initial begin
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
		end
		$display("Timeout: halt was not reached within %0d cycles", TIMEOUT_CYCLES);
		timeouts = timeouts + 1;
		report_summary();
		$finish;
	end

	initial begin
		reset = 1'b1;
		load_en = 1'b0;
		load_addr = '0;
		load_data = 32'd0;
		for (int p = 0; p < PROGRAMS; p++) begin
			@(negedge clk);
			reset = 1'b1;
			repeat (2) @(negedge clk);
			build_program(p);
			load_image();
			while (!halt) begin
				@(negedge clk);
			end
			// A few halted cycles to see the PC hold
			repeat (3) @(negedge clk);
		end
		report_summary();
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
verilog/cpu_pkg.sv
verilog/instr_decoder.sv
verilog/reg_file.sv
verilog/alu_shift.sv
verilog/next_pc_unit.sv
verilog/unified_memory.sv
verilog/cpu_top.sv
bench/cpu_checker.sv
bench/cpu_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps --top-module cpu_tb -f build.f -o cpu_sim
./obj_dir/cpu_sim | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
	echo "Simulation reported a failure, see sim.log"
	exit 1
fi
echo "Simulation finished without failures"
exit 0

//--- verilog/alu_shift.sv
`timescale 1ns/1ps
`default_nettype none

module alu_shift (
	input  wire cpu_pkg::alu_op_e op,
	input  wire [31:0]            a,
	input  wire [31:0]            b,
	input  wire [4:0]             shamt,
	output logic [31:0]           result
);

	logic [31:0] sum;
	logic [31:0] diff;
	logic        lt_signed;
	logic        lt_unsigned;

	assign sum = a + b;
	assign diff = a - b;
	assign lt_signed = $signed(a) < $signed(b);
	assign lt_unsigned = a < b;

	always_comb begin
		case (op)
			cpu_pkg::ALU_ADD:  result = sum;
			cpu_pkg::ALU_SUB:  result = diff;
			cpu_pkg::ALU_AND:  result = a & b;
			cpu_pkg::ALU_OR:   result = a | b;
			cpu_pkg::ALU_XOR:  result = a ^ b;
			cpu_pkg::ALU_NOR:  result = ~(a | b);
			cpu_pkg::ALU_SLT:  result = {31'd0, lt_signed};
			cpu_pkg::ALU_SLTU: result = {31'd0, lt_unsigned};
			// Immediate into the upper half
			cpu_pkg::ALU_LUI:  result = {b[15:0], 16'd0};
			// Shifter works on b, as in the rt operand
			cpu_pkg::ALU_SLL:  result = b << shamt;
			cpu_pkg::ALU_SRL:  result = b >> shamt;
			cpu_pkg::ALU_SRA:  result = $unsigned($signed(b) >>> shamt);
			default:           result = 32'd0;
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	// Primary opcodes
	typedef enum logic [5:0] {
		OPC_SPECIAL = 6'h00, OPC_J     = 6'h02, OPC_JAL   = 6'h03, OPC_BEQ   = 6'h04,
		OPC_BNE     = 6'h05, OPC_BLEZ  = 6'h06, OPC_BGTZ  = 6'h07, OPC_ADDIU = 6'h09,
		OPC_SLTI    = 6'h0a, OPC_SLTIU = 6'h0b, OPC_ANDI  = 6'h0c, OPC_ORI   = 6'h0d,
		OPC_XORI    = 6'h0e, OPC_LUI   = 6'h0f, OPC_LW    = 6'h23, OPC_SW    = 6'h2b
	} opcode_e;

	// Function codes under OPC_SPECIAL
	typedef enum logic [5:0] {
		FN_SLL  = 6'h00, FN_SRL  = 6'h02, FN_SRA  = 6'h03, FN_SLLV = 6'h04,
		FN_SRLV = 6'h06, FN_SRAV = 6'h07, FN_JR   = 6'h08, FN_JALR = 6'h09,
		FN_ADDU = 6'h21, FN_SUBU = 6'h23, FN_AND  = 6'h24, FN_OR   = 6'h25,
		FN_XOR  = 6'h26, FN_NOR  = 6'h27, FN_SLT  = 6'h2a, FN_SLTU = 6'h2b
	} funct_e;

	// R-type layout; imm and index overlay the low bits
	typedef struct packed {
		logic [5:0] opc;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] sa;
		logic [5:0] funct;
	} instr_fields_t;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
		ALU_SLT, ALU_SLTU, ALU_LUI, ALU_SLL, ALU_SRL, ALU_SRA
	} alu_op_e;

	typedef enum logic [2:0] {BR_NONE, BR_BEQ, BR_BNE, BR_BLEZ, BR_BGTZ} branch_e;
	typedef enum logic [1:0] {PC_SEQ, PC_BRANCH, PC_JUMP, PC_JREG} pc_sel_e;
	typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_LINK} wb_sel_e;
	typedef enum logic [1:0] {DEST_RD, DEST_RT, DEST_R31} dest_sel_e;

	typedef struct packed {
		alu_op_e   alu_op;
		logic      src_imm;
		logic      shift_var;
		logic      reg_we;
		dest_sel_e dest_sel;
		wb_sel_e   wb_sel;
		logic      mem_we;
		branch_e   branch;
		pc_sel_e   pc_sel;
	} ctrl_t;

	// One record per executed instruction
	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] instr;
		logic        reg_we;
		logic [4:0]  wb_addr;
		logic [31:0] wb_data;
		logic        mem_we;
		logic [31:0] mem_addr;
	} retire_t;

endpackage

`default_nettype wire

//--- verilog/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top #(
	parameter int          MEM_WORDS = 256,
	parameter logic [31:0] RESET_PC  = 32'h0000_0000
) (
	input  wire                         clk,
	input  wire                         reset,
	input  wire                         load_en,
	input  wire [$clog2(MEM_WORDS)-1:0] load_addr,
	input  wire [31:0]                  load_data,
	output logic                        halt,
	output cpu_pkg::retire_t            retire,
	output logic                        retire_valid
);

	cpu_pkg::instr_fields_t f;
	cpu_pkg::ctrl_t         ctrl;
	logic [31:0] pc, instr, imm_ext, link;
	logic [31:0] rs_val, rt_val, alu_b, alu_result, mem_rdata, wb_data;
	logic [4:0]  shamt, wb_addr;

	unified_memory #(.MEM_WORDS(MEM_WORDS)) u_mem (
		.clk, .reset, .load_en, .load_addr, .load_data,
		.iaddr(pc), .daddr(alu_result), .we(ctrl.mem_we), .wdata(rt_val),
		.idata(instr), .rdata(mem_rdata)
	);

	assign f = cpu_pkg::instr_fields_t'(instr);

	instr_decoder u_dec (.instr, .ctrl, .imm_ext, .halt);

	reg_file u_rf (
		.clk, .reset, .we(ctrl.reg_we), .waddr(wb_addr), .wdata(wb_data),
		.raddr_a(f.rs), .raddr_b(f.rt), .rdata_a(rs_val), .rdata_b(rt_val)
	);

	// Operand muxes
	assign alu_b = ctrl.src_imm ? imm_ext : rt_val;
	assign shamt = ctrl.shift_var ? rs_val[4:0] : f.sa;

	alu_shift u_alu (.op(ctrl.alu_op), .a(rs_val), .b(alu_b), .shamt, .result(alu_result));

	next_pc_unit #(.RESET_PC(RESET_PC)) u_npc (
		.clk, .reset, .ctrl, .rs_val, .rt_val,
		.imm(instr[15:0]), .index(instr[25:0]), .pc, .link
	);

	assign wb_addr = (ctrl.dest_sel == cpu_pkg::DEST_R31) ? 5'd31 :
			(ctrl.dest_sel == cpu_pkg::DEST_RT) ? f.rt : f.rd;
	assign wb_data = (ctrl.wb_sel == cpu_pkg::WB_MEM) ? mem_rdata :
			(ctrl.wb_sel == cpu_pkg::WB_LINK) ? link : alu_result;

	assign retire = '{pc: pc, instr: instr, reg_we: ctrl.reg_we, wb_addr: wb_addr,
			wb_data: wb_data, mem_we: ctrl.mem_we, mem_addr: alu_result};
	assign retire_valid = !reset && !halt;

endmodule

`default_nettype wire

//--- verilog/instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
	input  wire [31:0]      instr,
	output cpu_pkg::ctrl_t  ctrl,
	output logic [31:0]     imm_ext,
	output logic            halt
);

	cpu_pkg::instr_fields_t f;
	logic zero_ext;

	assign f = cpu_pkg::instr_fields_t'(instr);
	assign halt = (instr == 32'd0);

	// Logical immediates are zero extended
	assign zero_ext = (f.opc == cpu_pkg::OPC_ANDI) || (f.opc == cpu_pkg::OPC_ORI) ||
			(f.opc == cpu_pkg::OPC_XORI);
	assign imm_ext = zero_ext ? {16'd0, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};

	always_comb begin
		ctrl = '0;
		ctrl.alu_op = cpu_pkg::ALU_ADD;
		ctrl.dest_sel = cpu_pkg::DEST_RT;
		ctrl.wb_sel = cpu_pkg::WB_ALU;
		ctrl.branch = cpu_pkg::BR_NONE;
		ctrl.pc_sel = cpu_pkg::PC_SEQ;
		case (f.opc)
			cpu_pkg::OPC_SPECIAL: begin
				ctrl.reg_we = 1'b1;
				ctrl.dest_sel = cpu_pkg::DEST_RD;
				case (f.funct)
					cpu_pkg::FN_ADDU: ctrl.alu_op = cpu_pkg::ALU_ADD;
					cpu_pkg::FN_SUBU: ctrl.alu_op = cpu_pkg::ALU_SUB;
					cpu_pkg::FN_AND:  ctrl.alu_op = cpu_pkg::ALU_AND;
					cpu_pkg::FN_OR:   ctrl.alu_op = cpu_pkg::ALU_OR;
					cpu_pkg::FN_XOR:  ctrl.alu_op = cpu_pkg::ALU_XOR;
					cpu_pkg::FN_NOR:  ctrl.alu_op = cpu_pkg::ALU_NOR;
					cpu_pkg::FN_SLT:  ctrl.alu_op = cpu_pkg::ALU_SLT;
					cpu_pkg::FN_SLTU: ctrl.alu_op = cpu_pkg::ALU_SLTU;
					cpu_pkg::FN_SLL:  ctrl.alu_op = cpu_pkg::ALU_SLL;
					cpu_pkg::FN_SRL:  ctrl.alu_op = cpu_pkg::ALU_SRL;
					cpu_pkg::FN_SRA:  ctrl.alu_op = cpu_pkg::ALU_SRA;
					cpu_pkg::FN_SLLV: begin
						ctrl.alu_op = cpu_pkg::ALU_SLL;
						ctrl.shift_var = 1'b1;
					end
					cpu_pkg::FN_SRLV: begin
						ctrl.alu_op = cpu_pkg::ALU_SRL;
						ctrl.shift_var = 1'b1;
					end
					cpu_pkg::FN_SRAV: begin
						ctrl.alu_op = cpu_pkg::ALU_SRA;
						ctrl.shift_var = 1'b1;
					end
					cpu_pkg::FN_JR: begin
						ctrl.reg_we = 1'b0;
						ctrl.pc_sel = cpu_pkg::PC_JREG;
					end
					cpu_pkg::FN_JALR: begin
						ctrl.wb_sel = cpu_pkg::WB_LINK;
						ctrl.pc_sel = cpu_pkg::PC_JREG;
					end
					default: ctrl.reg_we = 1'b0;
				endcase
			end
			cpu_pkg::OPC_ADDIU, cpu_pkg::OPC_SLTI, cpu_pkg::OPC_SLTIU, cpu_pkg::OPC_ANDI,
			cpu_pkg::OPC_ORI, cpu_pkg::OPC_XORI, cpu_pkg::OPC_LUI, cpu_pkg::OPC_LW: begin
				ctrl.reg_we = 1'b1;
				ctrl.src_imm = 1'b1;
				case (f.opc)
					cpu_pkg::OPC_SLTI:  ctrl.alu_op = cpu_pkg::ALU_SLT;
					cpu_pkg::OPC_SLTIU: ctrl.alu_op = cpu_pkg::ALU_SLTU;
					cpu_pkg::OPC_ANDI:  ctrl.alu_op = cpu_pkg::ALU_AND;
					cpu_pkg::OPC_ORI:   ctrl.alu_op = cpu_pkg::ALU_OR;
					cpu_pkg::OPC_XORI:  ctrl.alu_op = cpu_pkg::ALU_XOR;
					cpu_pkg::OPC_LUI:   ctrl.alu_op = cpu_pkg::ALU_LUI;
					cpu_pkg::OPC_LW:    ctrl.wb_sel = cpu_pkg::WB_MEM;
					default:            ctrl.alu_op = cpu_pkg::ALU_ADD;
				endcase
			end
			cpu_pkg::OPC_SW: begin
				ctrl.src_imm = 1'b1;
				ctrl.mem_we = 1'b1;
			end
			cpu_pkg::OPC_BEQ: begin
				ctrl.pc_sel = cpu_pkg::PC_BRANCH;
				ctrl.branch = cpu_pkg::BR_BEQ;
			end
			cpu_pkg::OPC_BNE: begin
				ctrl.pc_sel = cpu_pkg::PC_BRANCH;
				ctrl.branch = cpu_pkg::BR_BNE;
			end
			cpu_pkg::OPC_BLEZ: begin
				ctrl.pc_sel = cpu_pkg::PC_BRANCH;
				ctrl.branch = cpu_pkg::BR_BLEZ;
			end
			cpu_pkg::OPC_BGTZ: begin
				ctrl.pc_sel = cpu_pkg::PC_BRANCH;
				ctrl.branch = cpu_pkg::BR_BGTZ;
			end
			cpu_pkg::OPC_J: ctrl.pc_sel = cpu_pkg::PC_JUMP;
			cpu_pkg::OPC_JAL: begin
				ctrl.pc_sel = cpu_pkg::PC_JUMP;
				ctrl.reg_we = 1'b1;
				ctrl.dest_sel = cpu_pkg::DEST_R31;
				ctrl.wb_sel = cpu_pkg::WB_LINK;
			end
			default: ctrl.reg_we = 1'b0;
		endcase

		// Halt word acts as beq r0,r0,0 so the PC spins in place
		if (halt) begin
			ctrl.reg_we = 1'b0;
			ctrl.mem_we = 1'b0;
			ctrl.pc_sel = cpu_pkg::PC_BRANCH;
			ctrl.branch = cpu_pkg::BR_BEQ;
		end
	end

endmodule

`default_nettype wire

//--- verilog/next_pc_unit.sv
`timescale 1ns/1ps
`default_nettype none

module next_pc_unit #(
	parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
	input  wire                 clk,
	input  wire                 reset,
	input  wire cpu_pkg::ctrl_t ctrl,
	input  wire [31:0]          rs_val,
	input  wire [31:0]          rt_val,
	input  wire [15:0]          imm,
	input  wire [25:0]          index,
	output logic [31:0]         pc,
	output logic [31:0]         link
);

	logic [31:0] br_target;
	logic [31:0] jump_target;
	logic [31:0] next_pc;
	logic        taken;

	assign link = pc + 32'd4;
	// Branch offset is taken from pc itself, not pc+4
	assign br_target = pc + {{14{imm[15]}}, imm, 2'b00};
	assign jump_target = {link[31:28], index, 2'b00};

	always_comb begin
		case (ctrl.branch)
			cpu_pkg::BR_BEQ:  taken = (rs_val == rt_val);
			cpu_pkg::BR_BNE:  taken = (rs_val != rt_val);
			cpu_pkg::BR_BLEZ: taken = ($signed(rs_val) <= 32'sd0);
			cpu_pkg::BR_BGTZ: taken = ($signed(rs_val) > 32'sd0);
			default:          taken = 1'b0;
		endcase
	end

	always_comb begin
		case (ctrl.pc_sel)
			cpu_pkg::PC_BRANCH: next_pc = taken ? br_target : link;
			cpu_pkg::PC_JUMP:   next_pc = jump_target;
			cpu_pkg::PC_JREG:   next_pc = rs_val;
			default:            next_pc = link;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= RESET_PC;
		end else begin
			pc <= next_pc;
		end
	end

endmodule

`default_nettype wire

//--- verilog/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
	input  wire        clk,
	input  wire        reset,
	input  wire        we,
	input  wire [4:0]  waddr,
	input  wire [31:0] wdata,
	input  wire [4:0]  raddr_a,
	input  wire [4:0]  raddr_b,
	output logic [31:0] rdata_a,
	output logic [31:0] rdata_b
);

	logic [31:0] regs [32];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= 32'd0;
			end
		end else if (we && waddr != 5'd0) begin
			regs[waddr] <= wdata;
		end
	end

	// r0 is hardwired
	assign rdata_a = (raddr_a == 5'd0) ? 32'd0 : regs[raddr_a];
	assign rdata_b = (raddr_b == 5'd0) ? 32'd0 : regs[raddr_b];

endmodule

`default_nettype wire

//--- verilog/unified_memory.sv
`timescale 1ns/1ps
`default_nettype none

module unified_memory #(
	parameter int MEM_WORDS = 256
) (
	input  wire                         clk,
	input  wire                         reset,
	input  wire                         load_en,
	input  wire [$clog2(MEM_WORDS)-1:0] load_addr,
	input  wire [31:0]                  load_data,
	input  wire [31:0]                  iaddr,
	input  wire [31:0]                  daddr,
	input  wire                         we,
	input  wire [31:0]                  wdata,
	output logic [31:0]                 idata,
	output logic [31:0]                 rdata
);

	localparam int AW = $clog2(MEM_WORDS);

	logic [31:0]   mem [MEM_WORDS];
	logic [AW-1:0] iidx;
	logic [AW-1:0] didx;

	// Byte address to word index, wrapping at the memory size
	assign iidx = iaddr[2 +: AW];
	assign didx = daddr[2 +: AW];

	assign idata = mem[iidx];
	assign rdata = mem[didx];

	// Load port owns the array while reset is held
	always_ff @(posedge clk) begin
		if (reset) begin
			if (load_en) begin
				mem[load_addr] <= load_data;
			end
		end else if (we) begin
			mem[didx] <= wdata;
		end
	end

endmodule

`default_nettype wire
